// ==== Bender.yml ====
package:
  name: dcache

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/dcache_pkg.sv
      - source/line_ram.sv
      - source/line_status.sv
      - source/load_store_align.sv
      - source/dcache_ctrl.sv
      - source/dcache_top.sv
  - target: test
    files:
      - dv/dcache_assertions.sv
      - dv/tb_dcache.sv

// ==== dv/dcache_assertions.sv ====
`timescale 1ns/1ns

module dcache_assertions (
    input logic                  clk_i,
    input logic                  rst_i,
    input dcache_pkg::core_req_t core_req_i,
    input dcache_pkg::core_rsp_t core_rsp_i,
    input logic                  mem_avail_i,
    input dcache_pkg::mem_req_t  mem_req_i,
    input dcache_pkg::mem_rsp_t  mem_rsp_i
);

    int   fail_count = 0;
    logic mem_pending;

    // one memory command outstanding until its ready
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            mem_pending <= 1'b0;
        end else if (mem_req_i.req) begin
            mem_pending <= 1'b1;
        end else if (mem_rsp_i.ready) begin
            mem_pending <= 1'b0;
        end
    end

    done_single_pulse: assert property (@(posedge clk_i) disable iff (!rst_i)
        core_rsp_i.done |=> !core_rsp_i.done)
    else begin
        $error("done stayed high for more than one cycle");
        fail_count++;
    end

    req_only_when_avail: assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_i.req |-> mem_avail_i)
    else begin
        $error("memory request while memory was unavailable");
        fail_count++;
    end

    done_needs_request: assert property (@(posedge clk_i) disable iff (!rst_i)
        core_rsp_i.done |-> core_req_i.valid)
    else begin
        $error("done without a valid core request");
        fail_count++;
    end

    // a refill may follow in the same cycle as the write-back ready
    one_req_in_flight: assert property (@(posedge clk_i) disable iff (!rst_i)
        mem_req_i.req |-> (!mem_pending || mem_rsp_i.ready))
    else begin
        $error("second memory request before ready");
        fail_count++;
    end

endmodule

bind dcache_top dcache_assertions asrt0 (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .core_req_i (core_req_i),
    .core_rsp_i (core_rsp_o),
    .mem_avail_i(mem_avail_i),
    .mem_req_i  (mem_req_o),
    .mem_rsp_i  (mem_rsp_i)
);

// ==== dv/tb_dcache.sv ====
`timescale 1ns/1ns

module tb_dcache;

    import dcache_pkg::*;

    localparam int MEM_BYTES  = 4096;
    localparam int N_ACCESSES = 52 + 1 + 12 + 1 + 1 + 200;
    localparam int MAX_CYCLES = 40 * N_ACCESSES;

    logic        clk_i = 1'b0;
    logic        rst_i;
    core_req_t   core_req;
    core_rsp_t   core_rsp;
    logic        mem_avail;
    mem_rsp_t    mem_rsp;
    mem_req_t    mem_req;

    logic [7:0]  ref_mem [MEM_BYTES];
    logic [7:0]  mem_model [MEM_BYTES];
    logic [31:0] lcg_state = 32'h4598_6db0;
    logic        hold_unavail = 1'b0;
    logic        mem_busy = 1'b0;
    logic        mem_refill;
    logic [11:0] mem_base;
    int          mem_delay;
    int          low_left = 0;
    line_t       expected_line;
    logic [31:0] last_wb_addr;
    int          wb_count = 0;
    int          refill_count = 0;
    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    int          latency;

    dcache_top #(
        .SETS(128)
    ) dut0 (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .core_req_i (core_req),
        .core_rsp_o (core_rsp),
        .mem_avail_i(mem_avail),
        .mem_rsp_i  (mem_rsp),
        .mem_req_o  (mem_req)
    );

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int random_below(input int n);
        return int'(next_random() >> 16) % n;
    endfunction

    function automatic int error_total();
        return errors + dut0.asrt0.fail_count;
    endfunction

    function automatic int access_size(input mem_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 1;
            OP_LH, OP_LHU, OP_SH: return 2;
            default:              return 4;
        endcase
    endfunction

    // little endian with RV32 sign and zero extension
    function automatic logic [31:0] expected_load(input mem_op_e op, input logic [11:0] addr);
        logic [31:0] raw;
        raw = {ref_mem[12'(addr + 3)], ref_mem[12'(addr + 2)],
               ref_mem[12'(addr + 1)], ref_mem[addr]};
        case (op)
            OP_LB:   return {{24{raw[7]}}, raw[7:0]};
            OP_LBU:  return {24'd0, raw[7:0]};
            OP_LH:   return {{16{raw[15]}}, raw[15:0]};
            OP_LHU:  return {16'd0, raw[15:0]};
            default: return raw;
        endcase
    endfunction

    task automatic apply_store(input mem_op_e op, input logic [11:0] addr,
                               input logic [31:0] wdata);
        for (int i = 0; i < access_size(op); i++) begin
            ref_mem[12'(addr + i)] = wdata[i*8 +: 8];
        end
    endtask

    // runs from a falling edge to the falling edge after done
    task automatic do_access(input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata);
        logic [31:0] expected;
        core_req.valid = 1'b1;
        core_req.op    = op;
        core_req.addr  = addr;
        core_req.wdata = wdata;
        @(posedge clk_i);
        latency = 0;
        while (!core_rsp.done) begin
            @(posedge clk_i);
            latency++;
        end
        if (op inside {OP_SB, OP_SH, OP_SW}) begin
            apply_store(op, addr[11:0], wdata);
        end else begin
            expected = expected_load(op, addr[11:0]);
            assert (core_rsp.rdata == expected) else begin
                $display("MISMATCH at %0t: %s at %h read %h, expected %h",
                         $time, op.name(), addr, core_rsp.rdata, expected);
                errors++;
            end
        end
        @(negedge clk_i);
        core_req.valid = 1'b0;
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (error_total() != errors_before) begin
            tests_failed++;
        end
        $display("test %-12s %s", name, (error_total() == errors_before) ? "ok" : "failed");
    endtask

    // line memory with random availability and a 2 to 5 cycle answer
    always begin
        @(posedge clk_i);
        if (rst_i && mem_req.req) begin
            mem_busy   = 1'b1;
            mem_refill = !mem_req.write;
            mem_base   = mem_req.addr[11:0];
            mem_delay  = 2 + random_below(4);
            if (mem_req.write) begin
                wb_count++;
                last_wb_addr = mem_req.addr;
                for (int i = 0; i < LINE_BYTES; i++) begin
                    expected_line[i*8 +: 8] = ref_mem[mem_base + i];
                    mem_model[mem_base + i] = mem_req.line[i*8 +: 8];
                end
                assert (mem_req.line == expected_line) else begin
                    $display("MISMATCH at %0t: write-back of %h carries %h, expected %h",
                             $time, mem_req.addr, mem_req.line, expected_line);
                    errors++;
                end
            end else begin
                refill_count++;
            end
        end
        @(negedge clk_i);
        mem_rsp.ready = 1'b0;
        if (mem_busy) begin
            mem_delay--;
            if (mem_delay == 0) begin
                mem_busy      = 1'b0;
                mem_rsp.ready = 1'b1;
                for (int i = 0; i < LINE_BYTES; i++) begin
                    mem_rsp.line[i*8 +: 8] = mem_refill ? mem_model[mem_base + i] : 8'h00;
                end
            end
        end
        if (hold_unavail) begin
            mem_avail = 1'b0;
        end else if (low_left > 0) begin
            mem_avail = 1'b0;
            low_left--;
        end else begin
            mem_avail = 1'b1;
            if (random_below(4) == 0) begin
                low_left = random_below(4);
            end
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: accesses still running after %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    initial begin
        int          errors_before;
        int          refills_before;
        int          wbs_before;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] word;
        mem_op_e     load_ops [5];
        load_ops  = '{OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
        rst_i     = 1'b0;
        core_req  = '0;
        mem_avail = 1'b0;
        mem_rsp   = '0;
        for (int a = 0; a < MEM_BYTES; a += 4) begin
            word = next_random();
            for (int b = 0; b < 4; b++) begin
                ref_mem[a + b]   = word[b*8 +: 8];
                mem_model[a + b] = word[b*8 +: 8];
            end
        end
        repeat (3) @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);

        // every load kind at every aligned offset of cold line 0x100
        errors_before  = error_total();
        refills_before = refill_count;
        foreach (load_ops[k]) begin
            for (int off = 0; off < LINE_BYTES; off += access_size(load_ops[k])) begin
                do_access(load_ops[k], 32'h100 + off, 32'd0);
            end
        end
        assert (refill_count == refills_before + 1) else begin
            $display("line 0x100 refilled %0d times, expected once",
                     refill_count - refills_before);
            errors++;
        end
        report_test("cold_loads", errors_before);

        errors_before  = error_total();
        refills_before = refill_count;
        do_access(OP_LW, 32'h108, 32'd0);
        assert (latency == 2 && refill_count == refills_before) else begin
            $display("hit on 0x108 finished %0d cycles after sampling, expected 2", latency);
            errors++;
        end
        report_test("hit_latency", errors_before);

        // hits on line 0x100, then misses on cold lines
        errors_before = error_total();
        do_access(OP_SB, 32'h104, next_random());
        do_access(OP_SH, 32'h10a, next_random());
        do_access(OP_SW, 32'h10c, next_random());
        do_access(OP_SW, 32'h200, next_random());
        do_access(OP_SH, 32'h306, next_random());
        do_access(OP_SB, 32'h40b, next_random());
        do_access(OP_LW, 32'h104, 32'd0);
        do_access(OP_LW, 32'h108, 32'd0);
        do_access(OP_LW, 32'h10c, 32'd0);
        do_access(OP_LW, 32'h200, 32'd0);
        do_access(OP_LW, 32'h304, 32'd0);
        do_access(OP_LW, 32'h408, 32'd0);
        report_test("stores", errors_before);

        // 0x900 maps onto the dirty set of 0x100
        errors_before  = error_total();
        refills_before = refill_count;
        wbs_before     = wb_count;
        do_access(OP_LW, 32'h904, 32'd0);
        assert (wb_count == wbs_before + 1 && last_wb_addr == 32'h100
                && refill_count == refills_before + 1) else begin
            $display("conflict on 0x900 gave %0d write-backs (last to %h) and %0d refills",
                     wb_count - wbs_before, last_wb_addr, refill_count - refills_before);
            errors++;
        end
        report_test("write_back", errors_before);

        errors_before  = error_total();
        refills_before = refill_count;
        hold_unavail   = 1'b1;
        @(negedge clk_i);
        fork
            do_access(OP_LH, 32'hc46, 32'd0);
            begin
                repeat (50) @(negedge clk_i);
                assert (refill_count == refills_before) else begin
                    $display("memory request issued while memory was held unavailable");
                    errors++;
                end
                hold_unavail = 1'b0;
            end
        join
        report_test("avail_stall", errors_before);

        // two tags per set over sets 0x00 to 0x0f
        errors_before = error_total();
        for (int n = 0; n < 200; n++) begin
            op   = mem_op_e'(random_below(8));
            addr = random_below(2) * 32'h800 + random_below(16) * 16 + random_below(16);
            addr = addr & ~32'(access_size(op) - 1);
            do_access(op, addr, next_random());
            // core drops valid for a cycle now and then
            if (random_below(4) == 0) begin
                @(negedge clk_i);
            end
        end
        report_test("random_mix", errors_before);

        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 tests_run, tests_failed, errors, dut0.asrt0.fail_count);
        if (error_total() == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== include/mem_ops.svh ====
`ifndef MEM_OPS_SVH
`define MEM_OPS_SVH

// memory operation encodings from the decode stage
`define MEM_LB  3'b000
`define MEM_LH  3'b001
`define MEM_LW  3'b010
`define MEM_LBU 3'b011
`define MEM_LHU 3'b100
`define MEM_SB  3'b101
`define MEM_SH  3'b110
`define MEM_SW  3'b111

`endif

// ==== source/dcache_ctrl.sv ====
`timescale 1ns/1ns

module dcache_ctrl #(
    parameter int SETS = 128
) (
    input  logic                       clk_i,
    input  logic                       rst_i,
    input  dcache_pkg::core_req_t      core_req_i,
    input  logic                       mem_avail_i,
    input  dcache_pkg::mem_rsp_t       mem_rsp_i,
    input  dcache_pkg::tag_entry_t     tag_rd_i,
    input  dcache_pkg::line_t          data_rd_i,
    input  logic                       valid_i,
    input  logic                       dirty_i,
    input  dcache_pkg::line_t          merged_line_i,
    output logic                       ram_en_o,
    output logic                       ram_we_o,
    output logic [$clog2(SETS)-1:0]    ram_index_o,
    output dcache_pkg::tag_entry_t     tag_wr_o,
    output dcache_pkg::line_t          data_wr_o,
    output logic                       set_valid_o,
    output logic                       set_dirty_o,
    output logic                       clear_dirty_o,
    output logic                       align_src_o,
    output logic                       done_o,
    output dcache_pkg::mem_req_t       mem_req_o
);

    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL
    } state_e;

    state_e                 state_q;
    state_e                 state_d;
    logic                   done_q;
    logic                   done_d;
    logic                   latch_victim;
    line_t                  victim_line_q;
    logic [LINE_ADDR_W-1:0] victim_addr_q;

    logic [LINE_ADDR_W-1:0] req_line_addr;
    logic                   is_store;
    logic                   tag_hit;

    assign req_line_addr = core_req_i.addr[31:OFFSET_W];
    assign is_store      = core_req_i.op inside {OP_SB, OP_SH, OP_SW};
    assign tag_hit       = valid_i && (tag_rd_i.line_addr == req_line_addr);

    // request is held until done, so it addresses every RAM access
    assign ram_index_o = core_req_i.addr[OFFSET_W +: IDX_W];

    always_comb begin
        state_d       = state_q;
        done_d        = 1'b0;
        latch_victim  = 1'b0;
        ram_en_o      = 1'b0;
        ram_we_o      = 1'b0;
        tag_wr_o      = tag_rd_i;
        data_wr_o     = merged_line_i;
        set_valid_o   = 1'b0;
        set_dirty_o   = 1'b0;
        clear_dirty_o = 1'b0;
        align_src_o   = 1'b0;
        done_o        = done_q;

        // victim stays on the bus while the write-back is pending
        mem_req_o.req   = 1'b0;
        mem_req_o.write = 1'b0;
        mem_req_o.addr  = {victim_addr_q, {OFFSET_W{1'b0}}};
        mem_req_o.line  = victim_line_q;

        unique case (state_q)
            IDLE: begin
                if (done_q) begin
                    // hit completes here, store hit writes back the merged line
                    if (is_store) begin
                        ram_en_o    = 1'b1;
                        ram_we_o    = 1'b1;
                        set_dirty_o = 1'b1;
                    end
                end else if (core_req_i.valid) begin
                    ram_en_o = 1'b1;
                    state_d  = LOOKUP;
                end
            end

            LOOKUP: begin
                if (tag_hit) begin
                    done_d  = 1'b1;
                    state_d = IDLE;
                end else if (mem_avail_i) begin
                    mem_req_o.req = 1'b1;
                    if (valid_i && dirty_i) begin
                        mem_req_o.write = 1'b1;
                        mem_req_o.addr  = {tag_rd_i.line_addr, {OFFSET_W{1'b0}}};
                        mem_req_o.line  = data_rd_i;
                        latch_victim    = 1'b1;
                        state_d         = WRITEBACK;
                    end else begin
                        mem_req_o.addr = {req_line_addr, {OFFSET_W{1'b0}}};
                        state_d        = REFILL;
                    end
                end
            end

            WRITEBACK: begin
                if (mem_rsp_i.ready) begin
                    clear_dirty_o = 1'b1;
                    // refill right away if memory still takes commands
                    if (mem_avail_i) begin
                        mem_req_o.req  = 1'b1;
                        mem_req_o.addr = {req_line_addr, {OFFSET_W{1'b0}}};
                        state_d        = REFILL;
                    end else begin
                        state_d = LOOKUP;
                    end
                end
            end

            REFILL: begin
                align_src_o = 1'b1;
                if (mem_rsp_i.ready) begin
                    done_o             = 1'b1;
                    ram_en_o           = 1'b1;
                    ram_we_o           = 1'b1;
                    tag_wr_o.line_addr = req_line_addr;
                    set_valid_o        = 1'b1;
                    if (is_store) begin
                        data_wr_o   = merged_line_i;
                        set_dirty_o = 1'b1;
                    end else begin
                        data_wr_o     = mem_rsp_i.line;
                        clear_dirty_o = 1'b1;
                    end
                    state_d = IDLE;
                end
            end

            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            done_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            done_q  <= done_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (latch_victim) begin
            victim_line_q <= data_rd_i;
            victim_addr_q <= tag_rd_i.line_addr;
        end
    end

endmodule

// ==== source/dcache_pkg.sv ====
package dcache_pkg;

    `include "mem_ops.svh"

    // line geometry
    localparam int LINE_BYTES  = 16;
    localparam int LINE_W      = LINE_BYTES * 8;
    localparam int OFFSET_W    = $clog2(LINE_BYTES);
    localparam int LINE_ADDR_W = 32 - OFFSET_W;

    typedef enum logic [2:0] {
        OP_LB  = `MEM_LB,
        OP_LH  = `MEM_LH,
        OP_LW  = `MEM_LW,
        OP_LBU = `MEM_LBU,
        OP_LHU = `MEM_LHU,
        OP_SB  = `MEM_SB,
        OP_SH  = `MEM_SH,
        OP_SW  = `MEM_SW
    } mem_op_e;

    typedef logic [LINE_W-1:0] line_t;

    // whole line address, so the set count can change freely
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] line_addr;
    } tag_entry_t;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
    } core_req_t;

    typedef struct packed {
        logic        done;
        logic [31:0] rdata;
    } core_rsp_t;

    typedef struct packed {
        logic        req;
        logic        write;
        logic [31:0] addr;
        line_t       line;
    } mem_req_t;

    typedef struct packed {
        logic  ready;
        line_t line;
    } mem_rsp_t;

endpackage

// ==== source/dcache_top.sv ====
`timescale 1ns/1ns

module dcache_top #(
    parameter int SETS = 128
) (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  dcache_pkg::core_req_t core_req_i,
    output dcache_pkg::core_rsp_t core_rsp_o,
    input  logic                  mem_avail_i,
    input  dcache_pkg::mem_rsp_t  mem_rsp_i,
    output dcache_pkg::mem_req_t  mem_req_o
);

    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    logic             ram_en;
    logic             ram_we;
    logic [IDX_W-1:0] ram_index;
    tag_entry_t       tag_wr;
    tag_entry_t       tag_rd;
    line_t            data_wr;
    line_t            data_rd;
    line_t            merged_line;
    line_t            align_line;
    logic             valid;
    logic             dirty;
    logic             set_valid;
    logic             set_dirty;
    logic             clear_dirty;
    logic             align_src;
    logic             done;
    logic [31:0]      rdata;

    dcache_ctrl #(
        .SETS(SETS)
    ) ctrl0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .core_req_i   (core_req_i),
        .mem_avail_i  (mem_avail_i),
        .mem_rsp_i    (mem_rsp_i),
        .tag_rd_i     (tag_rd),
        .data_rd_i    (data_rd),
        .valid_i      (valid),
        .dirty_i      (dirty),
        .merged_line_i(merged_line),
        .ram_en_o     (ram_en),
        .ram_we_o     (ram_we),
        .ram_index_o  (ram_index),
        .tag_wr_o     (tag_wr),
        .data_wr_o    (data_wr),
        .set_valid_o  (set_valid),
        .set_dirty_o  (set_dirty),
        .clear_dirty_o(clear_dirty),
        .align_src_o  (align_src),
        .done_o       (done),
        .mem_req_o    (mem_req_o)
    );

    line_ram #(
        .SETS   (SETS),
        .entry_t(tag_entry_t)
    ) tag_ram0 (
        .clk_i  (clk_i),
        .en_i   (ram_en),
        .we_i   (ram_we),
        .index_i(ram_index),
        .wdata_i(tag_wr),
        .rdata_o(tag_rd)
    );

    line_ram #(
        .SETS   (SETS),
        .entry_t(line_t)
    ) data_ram0 (
        .clk_i  (clk_i),
        .en_i   (ram_en),
        .we_i   (ram_we),
        .index_i(ram_index),
        .wdata_i(data_wr),
        .rdata_o(data_rd)
    );

    line_status #(
        .SETS(SETS)
    ) status0 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .index_i      (ram_index),
        .set_valid_i  (set_valid),
        .set_dirty_i  (set_dirty),
        .clear_dirty_i(clear_dirty),
        .valid_o      (valid),
        .dirty_o      (dirty)
    );

    // refill line while a refill completes, RAM line otherwise
    assign align_line = align_src ? mem_rsp_i.line : data_rd;

    load_store_align align0 (
        .op_i         (core_req_i.op),
        .offset_i     (core_req_i.addr[OFFSET_W-1:0]),
        .src_line_i   (align_line),
        .wdata_i      (core_req_i.wdata),
        .rdata_o      (rdata),
        .merged_line_o(merged_line)
    );

    assign core_rsp_o.done  = done;
    assign core_rsp_o.rdata = rdata;

endmodule

// ==== source/line_ram.sv ====
`timescale 1ns/1ns

module line_ram #(
    parameter int  SETS    = 128,
    parameter type entry_t = logic [31:0]
) (
    input  logic                    clk_i,
    input  logic                    en_i,
    input  logic                    we_i,
    input  logic [$clog2(SETS)-1:0] index_i,
    input  entry_t                  wdata_i,
    output entry_t                  rdata_o
);

    entry_t mem_q [SETS];
    entry_t rdata_q;

    // read-before-write, output only changes on an enabled cycle
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                mem_q[index_i] <= wdata_i;
            end
            rdata_q <= mem_q[index_i];
        end
    end

    assign rdata_o = rdata_q;

endmodule

// ==== source/line_status.sv ====
`timescale 1ns/1ns

module line_status #(
    parameter int SETS = 128
) (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic [$clog2(SETS)-1:0] index_i,
    input  logic                    set_valid_i,
    input  logic                    set_dirty_i,
    input  logic                    clear_dirty_i,
    output logic                    valid_o,
    output logic                    dirty_o
);

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            if (set_valid_i) begin
                valid_q[index_i] <= 1'b1;
            end
            // set wins over clear
            if (set_dirty_i) begin
                dirty_q[index_i] <= 1'b1;
            end else if (clear_dirty_i) begin
                dirty_q[index_i] <= 1'b0;
            end
        end
    end

    assign valid_o = valid_q[index_i];
    assign dirty_o = dirty_q[index_i];

endmodule

// ==== source/load_store_align.sv ====
`timescale 1ns/1ns

module load_store_align (
    input  dcache_pkg::mem_op_e                op_i,
    input  logic [dcache_pkg::OFFSET_W-1:0]    offset_i,
    input  dcache_pkg::line_t                  src_line_i,
    input  logic [31:0]                        wdata_i,
    output logic [31:0]                        rdata_o,
    output dcache_pkg::line_t                  merged_line_o
);

    import dcache_pkg::*;

    logic [OFFSET_W+2:0] bit_shift;
    line_t               shifted;
    line_t               field_mask;
    line_t               store_data;

    assign bit_shift = {offset_i, 3'b000};
    assign shifted   = src_line_i >> bit_shift;

    // load side
    always_comb begin
        unique case (op_i)
            OP_LB:   rdata_o = {{24{shifted[7]}}, shifted[7:0]};
            OP_LBU:  rdata_o = {24'd0, shifted[7:0]};
            OP_LH:   rdata_o = {{16{shifted[15]}}, shifted[15:0]};
            OP_LHU:  rdata_o = {16'd0, shifted[15:0]};
            default: rdata_o = shifted[31:0];
        endcase
    end

    // store side, field width from the op
    always_comb begin
        field_mask = '0;
        unique case (op_i)
            OP_SB:   field_mask[7:0]  = '1;
            OP_SH:   field_mask[15:0] = '1;
            OP_SW:   field_mask[31:0] = '1;
            default: field_mask       = '0;
        endcase
    end

    always_comb begin
        store_data        = '0;
        store_data[31:0]  = wdata_i;
        store_data        = store_data & field_mask;
        merged_line_o     = (src_line_i & ~(field_mask << bit_shift))
                          | (store_data << bit_shift);
    end

endmodule

// ==== tb.f ====
+incdir+include
source/dcache_pkg.sv
source/line_ram.sv
source/line_status.sv
source/load_store_align.sv
source/dcache_ctrl.sv
source/dcache_top.sv
dv/dcache_assertions.sv
dv/tb_dcache.sv
